// ==== include/muldiv_consts.svh ====
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Data path width
`define XLEN 32

// Operands carry one extra sign bit
`define EXT_W (`XLEN + 1)

// Full signed product of two extended operands
`define PROD_W (2 * `EXT_W)

`define MUL_STAGES 2 // Multiplier pipeline depth

`define DIV_ITERS 32 // One quotient bit per iteration
`define DIV_CNT_W 6

// Register number width
`define REG_AW 5

// Most negative XLEN value
`define XLEN_MIN {1'b1, {(`XLEN - 1){1'b0}}}

`endif

// ==== verilog/rv_isa_pkg.sv ====
`include "muldiv_consts.svh"

package rv_isa_pkg;

	// M extension, funct3 field with funct7 = 7'b0000001
	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} funct3_e;

	typedef struct packed {
		logic [6:0]         funct7;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		funct3_e            funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0]         opcode;
	} rtype_t;

	// Upper half of the encoding space is the divide group
	function automatic logic is_div(funct3_e f);
		return f[2];
	endfunction

	function automatic logic is_rem(funct3_e f);
		return f[2] & f[1];
	endfunction

endpackage

// ==== verilog/muldiv_pkg.sv ====
`include "muldiv_consts.svh"

package muldiv_pkg;

	// Request as it arrives from the issue stage
	typedef struct packed {
		rv_isa_pkg::rtype_t instr;
		logic [`XLEN-1:0]   a;
		logic [`XLEN-1:0]   b;
	} md_req_t;

	// Prepared operands, also the tag that follows an operation
	typedef struct packed {
		logic [`EXT_W-1:0]   a_ext;
		logic [`EXT_W-1:0]   b_ext;
		logic [`XLEN-1:0]    a_raw; // REM by zero returns this
		rv_isa_pkg::funct3_e op;
		logic [`REG_AW-1:0]  rd;
		logic                div_zero;
		logic                div_ovf;
	} md_ops_t;

	typedef struct packed {
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   result;
	} md_rsp_t;

endpackage

// ==== verilog/md_operand_prep.sv ====
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module md_operand_prep (
	input  muldiv_pkg::md_req_t req,
	output muldiv_pkg::md_ops_t ops
);

	rv_isa_pkg::funct3_e op;
	logic sign_a;
	logic sign_b;
	logic b_zero;
	logic ovf_pair;

	assign op = req.instr.funct3;

	// MULHSU is signed rs1 times unsigned rs2
	always_comb begin
		unique case (op)
			rv_isa_pkg::MUL,
			rv_isa_pkg::MULH,
			rv_isa_pkg::DIV,
			rv_isa_pkg::REM: begin
				sign_a = 1'b1;
				sign_b = 1'b1;
			end
			rv_isa_pkg::MULHSU: begin
				sign_a = 1'b1;
				sign_b = 1'b0;
			end
			default: begin
				sign_a = 1'b0;
				sign_b = 1'b0;
			end
		endcase
	end

	assign b_zero   = (req.b == '0);
	assign ovf_pair = (req.a == `XLEN_MIN) && (req.b == '1); // -2^31 / -1

	always_comb begin
		ops.a_ext    = {sign_a & req.a[`XLEN-1], req.a};
		ops.b_ext    = {sign_b & req.b[`XLEN-1], req.b};
		ops.a_raw    = req.a;
		ops.op       = op;
		ops.rd       = req.instr.rd;
		ops.div_zero = rv_isa_pkg::is_div(op) & b_zero;
		ops.div_ovf  = (op == rv_isa_pkg::DIV || op == rv_isa_pkg::REM) & ovf_pair;
	end

	// Special-case flags only ever reach the divider
	mul_no_flags: assert final (rv_isa_pkg::is_div(ops.op) || !(ops.div_zero || ops.div_ovf))
		else $error("special-case flag set on multiply op %s", ops.op.name());

endmodule

// ==== verilog/md_multiplier.sv ====
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module md_multiplier (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                en,
	input  logic                in_valid,
	input  muldiv_pkg::md_ops_t ops,
	output logic                out_valid,
	output logic [`PROD_W-1:0]  product,
	output muldiv_pkg::md_ops_t out_ops
);

	localparam int LO_W = `XLEN / 2;
	localparam int HI_W = `EXT_W - LO_W; // Signed upper slice, also holds lo plus a zero
	localparam int PP_W = 2 * HI_W;

	logic signed [HI_W-1:0] a_lo;
	logic signed [HI_W-1:0] a_hi;
	logic signed [HI_W-1:0] b_lo;
	logic signed [HI_W-1:0] b_hi;

	logic                   v1_q;
	muldiv_pkg::md_ops_t    ops1_q;
	logic signed [PP_W-1:0] pp_ll_q;
	logic signed [PP_W-1:0] pp_lh_q;
	logic signed [PP_W-1:0] pp_hl_q;
	logic signed [PP_W-1:0] pp_hh_q;

	logic signed [`PROD_W-1:0] ll_x;
	logic signed [`PROD_W-1:0] lh_x;
	logic signed [`PROD_W-1:0] hl_x;
	logic signed [`PROD_W-1:0] hh_x;
	logic signed [`PROD_W-1:0] sum;

	assign a_lo = $signed({1'b0, ops.a_ext[LO_W-1:0]});
	assign a_hi = $signed(ops.a_ext[`EXT_W-1:LO_W]);
	assign b_lo = $signed({1'b0, ops.b_ext[LO_W-1:0]});
	assign b_hi = $signed(ops.b_ext[`EXT_W-1:LO_W]);

	// Sign extension to full product width
	assign ll_x = pp_ll_q;
	assign lh_x = pp_lh_q;
	assign hl_x = pp_hl_q;
	assign hh_x = pp_hh_q;
	assign sum  = (hh_x <<< (2 * LO_W)) + ((lh_x + hl_x) <<< LO_W) + ll_x;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v1_q      <= 1'b0;
			out_valid <= 1'b0;
		end else if (en) begin
			v1_q      <= in_valid;
			out_valid <= v1_q;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			ops1_q  <= ops;
			pp_ll_q <= a_lo * b_lo;
			pp_lh_q <= a_lo * b_hi;
			pp_hl_q <= a_hi * b_lo;
			pp_hh_q <= a_hi * b_hi;
			out_ops <= ops1_q;
			product <= sum;
		end
	end

	valid_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(out_valid))
		else $error("multiplier out_valid unknown");

endmodule

// ==== verilog/md_divider.sv ====
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module md_divider (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  muldiv_pkg::md_ops_t ops,
	input  logic                hold,
	output logic                busy,
	output logic                done,
	output logic [`XLEN-1:0]    quotient,
	output logic [`XLEN-1:0]    remainder,
	output muldiv_pkg::md_ops_t out_ops
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FIN
	} state_e;

	state_e                state;
	logic [`DIV_CNT_W-1:0] cnt;

	logic [`XLEN-1:0]  a_mag;
	logic [`XLEN-1:0]  b_mag;
	logic [`XLEN-1:0]  quo_q; // Dividend shifts out, quotient shifts in
	logic [`XLEN-1:0]  rem_q;
	logic [`XLEN-1:0]  dvs_q;
	logic [`EXT_W-1:0] shifted;
	logic [`EXT_W:0]   diff;
	logic              q_neg;
	logic              r_neg;

	// Extended sign bit is zero for unsigned ops
	assign a_mag = ops.a_ext[`EXT_W-1] ? -ops.a_ext[`XLEN-1:0] : ops.a_ext[`XLEN-1:0];
	assign b_mag = ops.b_ext[`EXT_W-1] ? -ops.b_ext[`XLEN-1:0] : ops.b_ext[`XLEN-1:0];

	assign shifted = {rem_q, quo_q[`XLEN-1]};
	assign diff    = {1'b0, shifted} - {2'b00, dvs_q}; // MSB set means restore

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					if (start) begin
						state <= RUN;
						cnt   <= '0;
					end
				end
				RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == `DIV_CNT_W'(`DIV_ITERS - 1))
						state <= FIN;
				end
				FIN: begin
					if (!hold)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			quo_q   <= a_mag;
			rem_q   <= '0;
			dvs_q   <= b_mag;
			out_ops <= ops;
		end else if (state == RUN) begin
			quo_q <= {quo_q[`XLEN-2:0], ~diff[`EXT_W]};
			rem_q <= diff[`EXT_W] ? shifted[`XLEN-1:0] : diff[`XLEN-1:0];
		end
	end

	// Truncation toward zero, remainder follows the dividend
	assign q_neg     = out_ops.a_ext[`EXT_W-1] ^ out_ops.b_ext[`EXT_W-1];
	assign r_neg     = out_ops.a_ext[`EXT_W-1];
	assign quotient  = q_neg ? -quo_q : quo_q;
	assign remainder = r_neg ? -rem_q : rem_q;

	assign busy = (state != IDLE);
	assign done = (state == FIN);

	start_when_idle: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
		else $error("divider started while busy");

endmodule

// ==== verilog/md_result_sel.sv ====
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module md_result_sel (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                mul_valid,
	input  logic [`PROD_W-1:0]  product,
	input  muldiv_pkg::md_ops_t mul_ops,
	input  logic                div_done,
	input  logic [`XLEN-1:0]    quotient,
	input  logic [`XLEN-1:0]    remainder,
	input  muldiv_pkg::md_ops_t div_ops,
	input  logic                rsp_ready,
	output logic                stall,
	output logic                rsp_valid,
	output muldiv_pkg::md_rsp_t rsp
);

	logic                new_valid;
	logic                load;
	logic [`XLEN-1:0]    mul_word;
	logic [`XLEN-1:0]    div_word;
	muldiv_pkg::md_rsp_t next_rsp;

	assign new_valid = mul_valid | div_done;
	assign stall     = new_valid & rsp_valid & ~rsp_ready; // Full and not draining
	assign load      = new_valid & ~stall;

	assign mul_word = (mul_ops.op == rv_isa_pkg::MUL) ?
		product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];

	// Divide by zero and overflow results per the RISC-V spec
	always_comb begin
		if (rv_isa_pkg::is_rem(div_ops.op)) begin
			if (div_ops.div_zero)
				div_word = div_ops.a_raw;
			else if (div_ops.div_ovf)
				div_word = '0;
			else
				div_word = remainder;
		end else begin
			if (div_ops.div_zero)
				div_word = '1;
			else if (div_ops.div_ovf)
				div_word = `XLEN_MIN;
			else
				div_word = quotient;
		end
	end

	always_comb begin
		next_rsp.rd     = mul_valid ? mul_ops.rd : div_ops.rd;
		next_rsp.result = mul_valid ? mul_word : div_word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rsp_valid <= 1'b0;
		else if (load)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load)
			rsp <= next_rsp;
	end

	// Ordering rule at the top keeps the two sources apart
	one_source: assert property (@(posedge clk) disable iff (!arst_n) !(mul_valid && div_done))
		else $error("multiplier and divider results collide");

endmodule

// ==== verilog/mult_div.sv ====
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module mult_div (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,
	output logic                req_ready,
	input  muldiv_pkg::md_req_t req,
	output logic                rsp_valid,
	input  logic                rsp_ready,
	output muldiv_pkg::md_rsp_t rsp
);

	localparam int CNT_W = $clog2(`MUL_STAGES + 1);

	muldiv_pkg::md_ops_t ops;
	muldiv_pkg::md_ops_t mul_out;
	muldiv_pkg::md_ops_t div_out;

	logic [`PROD_W-1:0] product;
	logic [`XLEN-1:0]   quotient;
	logic [`XLEN-1:0]   remainder;
	logic               is_div;
	logic               accept;
	logic               mul_start;
	logic               div_start;
	logic               mul_out_valid;
	logic               mul_retire;
	logic               div_done;
	logic               div_busy;
	logic               stall;
	logic [CNT_W-1:0]   mul_cnt; // Multiplies not yet in the response register

	assign is_div = rv_isa_pkg::is_div(req.instr.funct3);

	// Divide waits for an empty multiplier so responses stay in order
	assign req_ready  = !div_busy && !stall && (!is_div || mul_cnt == '0);
	assign accept     = req_valid && req_ready;
	assign mul_start  = accept && !is_div;
	assign div_start  = accept && is_div;
	assign mul_retire = mul_out_valid && !stall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mul_cnt <= '0;
		else if (mul_start && !mul_retire)
			mul_cnt <= mul_cnt + 1'b1;
		else if (mul_retire && !mul_start)
			mul_cnt <= mul_cnt - 1'b1;
	end

	md_operand_prep prep0 (
		.req (req),
		.ops (ops)
	);

	md_multiplier mul0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.en        (!stall),
		.in_valid  (mul_start),
		.ops       (ops),
		.out_valid (mul_out_valid),
		.product   (product),
		.out_ops   (mul_out)
	);

	md_divider div0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (div_start),
		.ops       (ops),
		.hold      (stall),
		.busy      (div_busy),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder),
		.out_ops   (div_out)
	);

	md_result_sel sel0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.mul_valid (mul_out_valid),
		.product   (product),
		.mul_ops   (mul_out),
		.div_done  (div_done),
		.quotient  (quotient),
		.remainder (remainder),
		.div_ops   (div_out),
		.rsp_ready (rsp_ready),
		.stall     (stall),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS  = 100,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// ==== verification/tb_mult_div.sv ====
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module tb_mult_div;

	localparam int PERIOD_NS  = 100;
	localparam int RST_CYCLES = 16;
	localparam int N_RANDOM   = 8;

	typedef struct packed {
		rv_isa_pkg::funct3_e op;
		logic [`XLEN-1:0]    a;
		logic [`XLEN-1:0]    b;
		logic [`REG_AW-1:0]  rd;
		logic [`XLEN-1:0]    result;
		logic [3:0]          stall; // Cycles with rsp_ready low
		logic [5:0]          lat;   // Zero when latency is not measured
	} row_t;

	logic                clk;
	logic                arst_n;
	logic                req_valid;
	logic                req_ready;
	muldiv_pkg::md_req_t req;
	logic                rsp_valid;
	logic                rsp_ready;
	muldiv_pkg::md_rsp_t rsp;

	row_t                tbl[$];
	string               names[$];
	int                  exp_q[$]; // Table indices in request order
	int                  seed;
	int                  pass_cnt;
	int                  fail_cnt;
	int                  err_cnt;
	logic                tbl_ready;
	logic                held;
	muldiv_pkg::md_rsp_t held_rsp;

	tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) clk0 (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mult_div dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	// RISC-V M extension results, spec special cases included
	function automatic logic [`XLEN-1:0] ref_result(rv_isa_pkg::funct3_e op,
			logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		logic [63:0] p;
		logic [63:0] q;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = longint'({32'd0, a});
		ub = longint'({32'd0, b});
		p = 64'd0;
		q = 64'd0;
		case (op)
			rv_isa_pkg::MUL, rv_isa_pkg::MULH: p = sa * sb;
			rv_isa_pkg::MULHSU: p = sa * ub;
			rv_isa_pkg::MULHU: p = ua * ub;
			rv_isa_pkg::DIV: q = (b == 0) ? -1 : (a == 32'h80000000 && b == '1) ? sa : sa / sb;
			rv_isa_pkg::DIVU: q = (b == 0) ? -1 : ua / ub;
			rv_isa_pkg::REM: q = (b == 0) ? sa : (a == 32'h80000000 && b == '1) ? 0 : sa % sb;
			default: q = (b == 0) ? ua : ua % ub;
		endcase
		if (op == rv_isa_pkg::MUL)
			return p[`XLEN-1:0];
		else if (op == rv_isa_pkg::MULH || op == rv_isa_pkg::MULHSU ||
				op == rv_isa_pkg::MULHU)
			return p[63:32];
		return q[`XLEN-1:0];
	endfunction

	task automatic add_row(string name, rv_isa_pkg::funct3_e op, logic [`XLEN-1:0] a,
			logic [`XLEN-1:0] b, int rd, logic [`XLEN-1:0] result, int stall, int lat = 0);
		row_t r;
		r.op     = op;
		r.a      = a;
		r.b      = b;
		r.rd     = rd[`REG_AW-1:0];
		r.result = result;
		r.stall  = stall[3:0];
		r.lat    = lat[5:0];
		tbl.push_back(r);
		names.push_back(name);
	endtask

	task automatic check_idle(string when);
		assert (!rsp_valid) else begin
			$display("rsp_valid is high %s", when);
			err_cnt++;
		end
		assert (req_ready) else begin
			$display("req_ready is low %s", when);
			err_cnt++;
		end
	endtask

	// Starts and ends on a falling edge
	task automatic apply_row(int idx);
		int edges;
		req.instr        = '0;
		req.instr.funct7 = 7'b0000001;
		req.instr.opcode = 7'b0110011;
		req.instr.funct3 = tbl[idx].op;
		req.instr.rd     = tbl[idx].rd;
		req.a            = tbl[idx].a;
		req.b            = tbl[idx].b;
		req_valid        = 1'b1;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
		exp_q.push_back(idx);
		@(negedge clk);
		if (tbl[idx].lat != 0) begin
			req_valid = 1'b0;
			edges = 0;
			do begin
				@(posedge clk);
				edges++;
			end while (!rsp_valid && edges < 64);
			assert (edges == tbl[idx].lat) else begin
				$display("error: %s latency expected %0d actual %0d", names[idx], tbl[idx].lat,
					edges);
				err_cnt++;
			end
			@(negedge clk);
		end
	endtask

	// Scoreboard
	always @(posedge clk) begin
		muldiv_pkg::md_rsp_t want;
		int idx;
		if (held) begin
			assert (rsp_valid && rsp == held_rsp) else begin
				$display("response changed or vanished while rsp_ready was low");
				err_cnt++;
			end
		end
		if (rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				$display("response for rd %0d arrived with no request waiting", rsp.rd);
				err_cnt++;
			end else begin
				idx = exp_q.pop_front();
				want.rd = tbl[idx].rd;
				want.result = tbl[idx].result;
				assert (rsp == want) begin
					$display("ok: %s rd %0d result %h", names[idx], rsp.rd, rsp.result);
					pass_cnt++;
				end else begin
					$display("error: %s expected rd %0d result %h, actual rd %0d result %h",
						names[idx], want.rd, want.result, rsp.rd, rsp.result);
					fail_cnt++;
				end
			end
		end
		held = rsp_valid && !rsp_ready;
		held_rsp = rsp;
	end

	// Sink holds off each response for its row's stall count
	initial begin
		int   left;
		logic armed;
		rsp_ready = 1'b1;
		armed = 1'b0;
		left = 0;
		forever begin
			@(negedge clk);
			if (rsp_valid && !armed && exp_q.size() != 0) begin
				armed = 1'b1;
				left = tbl[exp_q[0]].stall;
			end
			if (armed && left > 0) begin
				rsp_ready = 1'b0;
				left--;
			end else begin
				rsp_ready = 1'b1;
				armed = 1'b0;
			end
		end
	end

	initial begin
		wait (tbl_ready);
		#((RST_CYCLES + 40 * tbl.size()) * PERIOD_NS);
		$display("run timed out with %0d responses missing", exp_q.size());
		$display("test failed");
		$finish;
	end

	initial begin
		rv_isa_pkg::funct3_e op;
		logic [`XLEN-1:0]    a;
		logic [`XLEN-1:0]    b;
		req_valid = 1'b0;
		req       = '0;
		held      = 1'b0;
		held_rsp  = '0;
		tbl_ready = 1'b0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		err_cnt   = 0;
		seed      = 32'h087a505c;

		add_row("lat_mul", rv_isa_pkg::MUL, 32'd3, 32'd4, 30, 32'd12, 0, 3);
		add_row("lat_div", rv_isa_pkg::DIVU, 32'd100, 32'd7, 31, 32'd14, 0, 34);
		add_row("mul_pos", rv_isa_pkg::MUL, 32'd7, 32'd6, 1, 32'd42, 0);
		add_row("mul_neg", rv_isa_pkg::MUL, 32'hfffffffd, 32'd5, 2, 32'hfffffff1, 0);
		add_row("mul_min_sq", rv_isa_pkg::MUL, 32'h80000000, 32'h80000000, 3, 32'd0, 0);
		add_row("mulh_min_sq", rv_isa_pkg::MULH, 32'h80000000, 32'h80000000, 4, 32'h40000000, 0);
		add_row("mulh_mixed", rv_isa_pkg::MULH, 32'hffffffff, 32'd2, 5, 32'hffffffff, 4);
		add_row("mulhsu_neg", rv_isa_pkg::MULHSU, 32'hffffffff, 32'hffffffff, 6, 32'hffffffff, 2);
		add_row("mulhsu_pos", rv_isa_pkg::MULHSU, 32'd2, 32'h80000000, 7, 32'd1, 0);
		add_row("mulhu_max", rv_isa_pkg::MULHU, 32'hffffffff, 32'hffffffff, 8, 32'hfffffffe, 0);
		add_row("div_pp", rv_isa_pkg::DIV, 32'd20, 32'd3, 9, 32'd6, 0);
		add_row("div_np", rv_isa_pkg::DIV, 32'hffffffec, 32'd3, 10, 32'hfffffffa, 0);
		add_row("div_pn", rv_isa_pkg::DIV, 32'd20, 32'hfffffffd, 11, 32'hfffffffa, 0);
		add_row("div_nn", rv_isa_pkg::DIV, 32'hffffffec, 32'hfffffffd, 12, 32'd6, 3);
		add_row("rem_pp", rv_isa_pkg::REM, 32'd20, 32'd3, 28, 32'd2, 0);
		add_row("rem_np", rv_isa_pkg::REM, 32'hffffffec, 32'd3, 13, 32'hfffffffe, 0);
		add_row("rem_pn", rv_isa_pkg::REM, 32'd20, 32'hfffffffd, 14, 32'd2, 0);
		add_row("rem_nn", rv_isa_pkg::REM, 32'hffffffec, 32'hfffffffd, 15, 32'hfffffffe, 0);
		add_row("divu_big", rv_isa_pkg::DIVU, 32'hffffffec, 32'd3, 16, 32'h5555554e, 0);
		add_row("remu_big", rv_isa_pkg::REMU, 32'hffffffec, 32'd3, 17, 32'd2, 0);
		add_row("div_zero", rv_isa_pkg::DIV, 32'd1234, 32'd0, 18, 32'hffffffff, 0);
		add_row("divu_zero", rv_isa_pkg::DIVU, 32'd5, 32'd0, 19, 32'hffffffff, 0);
		add_row("rem_zero", rv_isa_pkg::REM, 32'hffffffec, 32'd0, 20, 32'hffffffec, 5);
		add_row("remu_zero", rv_isa_pkg::REMU, 32'h12345678, 32'd0, 21, 32'h12345678, 0);
		add_row("div_ovf", rv_isa_pkg::DIV, 32'h80000000, 32'hffffffff, 22, 32'h80000000, 0);
		add_row("rem_ovf", rv_isa_pkg::REM, 32'h80000000, 32'hffffffff, 23, 32'd0, 1);
		add_row("mul_burst", rv_isa_pkg::MUL, 32'h00010001, 32'h00010001, 24, 32'h00020001, 3);
		add_row("mulhu_burst", rv_isa_pkg::MULHU, 32'h00010001, 32'h00010001, 25, 32'd1, 0);
		add_row("divu_after", rv_isa_pkg::DIVU, 32'd100, 32'd9, 26, 32'd11, 0);
		for (int i = 0; i < N_RANDOM; i++) begin
			op = rv_isa_pkg::funct3_e'($random(seed) & 7);
			a = $random(seed);
			b = $random(seed);
			add_row($sformatf("rand_%0d", i), op, a, b, 24 + i, ref_result(op, a, b),
				$unsigned($random(seed)) % 4);
		end
		tbl_ready = 1'b1;

		repeat (8) @(negedge clk);
		check_idle("during reset");
		wait (arst_n);
		@(negedge clk);
		check_idle("right after reset");

		for (int i = 0; i < tbl.size(); i++) begin
			// Timed rows start on an empty unit
			if (tbl[i].lat != 0) begin
				req_valid = 1'b0;
				while (exp_q.size() != 0)
					@(negedge clk);
			end
			apply_row(i);
		end
		req_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk); // Room for a stray duplicate

		$display("summary: %0d tests passed, %0d tests failed, %0d other errors",
			pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == tbl.size())
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/rv_isa_pkg.sv
verilog/muldiv_pkg.sv
verilog/md_operand_prep.sv
verilog/md_multiplier.sv
verilog/md_divider.sv
verilog/md_result_sel.sv
verilog/mult_div.sv
verification/tb_clock_gen.sv
verification/tb_mult_div.sv
